// File: source/uart_link_settings.svh
/*
 * Build-time constants for the framed UART link.
 * Pulled in by the packages and by the modules that size counters or buffers.
 */
`ifndef UART_LINK_SETTINGS_SVH
`define UART_LINK_SETTINGS_SVH

// sys_clk cycles per serial bit
`define UART_CLKS_PER_BIT 16

// bytes held by each of the tx and rx buffers
`define LINK_BUF_BYTES 16

// byte index width into a buffer
`define LINK_BUF_AW 4

`endif

// File: source/uart_frame_pkg.sv
/*
 * Types shared by the serial and framing blocks.
 * Refer to them with uart_frame_pkg:: scoped names.
 */
`include "uart_link_settings.svh"

package uart_frame_pkg;

	// one byte on the serial line
	typedef logic [7:0] frame_byte_t;

	// payload length, 0 up to a full buffer
	typedef logic [4:0] frame_len_t;

	// byte index into a tx or rx buffer
	typedef logic [`LINK_BUF_AW-1:0] buf_addr_t;

	// two of these open a frame and two close it
	localparam frame_byte_t FRAME_MARK = 8'h26;

endpackage

// File: source/axil_regs_pkg.sv
/*
 * Register map of the AXI4-Lite slave: byte offsets, CTRL bits and STATUS layout.
 */
package axil_regs_pkg;

	typedef enum logic [7:0] {
		CTRL    = 8'h00,
		STATUS  = 8'h04,
		TX_LEN  = 8'h08,
		RX_LEN  = 8'h0C,
		TX_BUF0 = 8'h10,
		TX_BUF1 = 8'h14,
		TX_BUF2 = 8'h18,
		TX_BUF3 = 8'h1C,
		RX_BUF0 = 8'h20,
		RX_BUF1 = 8'h24,
		RX_BUF2 = 8'h28,
		RX_BUF3 = 8'h2C
	} reg_off_e;

	// CTRL bits, both self-clearing
	localparam int CTRL_TX_START = 0;
	localparam int CTRL_RX_CLEAR = 1;

	typedef struct packed {
		logic [28:0] rsvd;
		logic        rx_overflow;
		logic        rx_ready;
		logic        tx_busy;
	} status_t;

endpackage

// File: source/frame_if.sv
/*
 * Interfaces between the register block and the two framers.
 * frame_tx_if feeds the transmit framer, frame_rx_if carries received frames back.
 */
`timescale 1ns/10ps

interface frame_tx_if;
	logic                      start;
	uart_frame_pkg::frame_len_t  len;
	uart_frame_pkg::buf_addr_t   rd_addr;
	uart_frame_pkg::frame_byte_t rd_data;
	logic                      busy;
	logic                      done;

	modport regs (output start, len, rd_data, input rd_addr, busy, done);
	modport framer (input start, len, rd_data, output rd_addr, busy, done);
endinterface

interface frame_rx_if;
	logic                      wr_en;
	uart_frame_pkg::buf_addr_t   wr_addr;
	uart_frame_pkg::frame_byte_t wr_data;
	uart_frame_pkg::frame_len_t  len;
	logic                      frame_ok;
	logic                      overflow;
	logic                      buf_free;

	modport regs (
		input wr_en, wr_addr, wr_data, len, frame_ok, overflow,
		output buf_free
	);
	modport deframer (
		output wr_en, wr_addr, wr_data, len, frame_ok, overflow,
		input buf_free
	);
endinterface

// File: source/uart_tx.sv
/*
 * 8N1 serializer. A req while idle loads one byte, which goes out as start bit,
 * eight data bits LSB first and a stop bit; done pulses after the stop bit.
 */
`timescale 1ns/10ps
`include "uart_link_settings.svh"

module uart_tx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        req,
	input  uart_frame_pkg::frame_byte_t data,
	output logic                        line,
	output logic                        done
);

	localparam int CW = $clog2(`UART_CLKS_PER_BIT);

	logic          busy;
	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_cnt;
	// stop, data, start; all ones when idle
	logic [9:0]    shift;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shift   <= '1;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (req) begin
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
					shift   <= {1'b1, data, 1'b0};
				end
			end else if (clk_cnt == CW'(`UART_CLKS_PER_BIT - 1)) begin
				clk_cnt <= '0;
				shift   <= {1'b1, shift[9:1]};
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + CW'(1);
			end
		end
	end

	assign line = shift[0];

endmodule

// File: source/uart_rx.sv
/*
 * 8N1 deserializer. A falling edge starts a bit timer; each bit is sampled
 * at mid-period and vld pulses at mid stop bit when the stop bit is high.
 */
`timescale 1ns/10ps
`include "uart_link_settings.svh"

module uart_rx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        line,
	output uart_frame_pkg::frame_byte_t data,
	output logic                        vld
);

	localparam int CW = $clog2(`UART_CLKS_PER_BIT);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

	rx_state_e     state;
	logic [2:0]    sync;
	logic          fall;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_cnt;
	logic [7:0]    shift;

	// two flops into the clock domain, a third for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			sync <= '1;
		else
			sync <= {sync[1:0], line};
	end

	assign fall = sync[2] && !sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			vld     <= 1'b0;
		end else begin
			vld <= 1'b0;
			case (state)
				IDLE: if (fall) begin
					state   <= START;
					clk_cnt <= '0;
				end
				START: if (clk_cnt == CW'(`UART_CLKS_PER_BIT / 2 - 1)) begin
					// glitch if the line is back high at mid start bit
					state   <= sync[1] ? IDLE : DATA;
					clk_cnt <= '0;
					bit_cnt <= '0;
				end else begin
					clk_cnt <= clk_cnt + CW'(1);
				end
				DATA: if (clk_cnt == CW'(`UART_CLKS_PER_BIT - 1)) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= STOP;
				end else begin
					clk_cnt <= clk_cnt + CW'(1);
				end
				STOP: if (clk_cnt == CW'(`UART_CLKS_PER_BIT - 1)) begin
					state <= IDLE;
					vld   <= sync[1];
				end else begin
					clk_cnt <= clk_cnt + CW'(1);
				end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == DATA && clk_cnt == CW'(`UART_CLKS_PER_BIT - 1))
			shift <= {sync[1], shift[7:1]};
	end

	assign data = shift;

endmodule

// File: source/frame_tx.sv
/*
 * Transmit framer. On start it sends "&&", len bytes read from the tx buffer,
 * then "&&", one uart_tx request per byte, and pulses done at the end.
 */
`timescale 1ns/10ps
`include "uart_link_settings.svh"

module frame_tx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	frame_tx_if.framer                  tx,
	output logic                        byte_req,
	output uart_frame_pkg::frame_byte_t byte_data,
	input  logic                        byte_done
);

	typedef enum logic [2:0] {IDLE, MARK1, MARK2, PAYLOAD, MARK3, MARK4} tx_state_e;

	tx_state_e                  state;
	uart_frame_pkg::frame_len_t len_q;
	// payload bytes already handed to uart_tx
	uart_frame_pkg::frame_len_t sent;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= IDLE;
			sent     <= '0;
			byte_req <= 1'b0;
			tx.busy  <= 1'b0;
			tx.done  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx.done  <= 1'b0;
			case (state)
				IDLE: if (tx.start) begin
					state    <= MARK1;
					sent     <= '0;
					byte_req <= 1'b1;
					tx.busy  <= 1'b1;
				end
				MARK1: if (byte_done) begin
					state    <= MARK2;
					byte_req <= 1'b1;
				end
				MARK2: if (byte_done) begin
					// empty payload skips straight to the closing marks
					state    <= (len_q == '0) ? MARK3 : PAYLOAD;
					sent     <= (len_q == '0) ? sent : sent + 5'd1;
					byte_req <= 1'b1;
				end
				PAYLOAD: if (byte_done) begin
					if (sent == len_q)
						state <= MARK3;
					else
						sent <= sent + 5'd1;
					byte_req <= 1'b1;
				end
				MARK3: if (byte_done) begin
					state    <= MARK4;
					byte_req <= 1'b1;
				end
				MARK4: if (byte_done) begin
					state   <= IDLE;
					tx.busy <= 1'b0;
					tx.done <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// byte for the next request, chosen alongside byte_req
	always_ff @(posedge sys_clk) begin
		if (state == IDLE && tx.start)
			len_q <= tx.len;
		if ((state == MARK2 || state == PAYLOAD) && byte_done && sent != len_q)
			byte_data <= tx.rd_data;
		else
			byte_data <= uart_frame_pkg::FRAME_MARK;
	end

	assign tx.rd_addr = sent[`LINK_BUF_AW-1:0];

endmodule

// File: source/frame_rx.sv
/*
 * Receive deframer. Hunts for "&&", writes the payload into the rx buffer and
 * reports the frame on the closing "&&"; frame_ok, overflow and the buffer
 * write are driven in the same cycle as the byte that causes them.
 */
`timescale 1ns/10ps
`include "uart_link_settings.svh"

module frame_rx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	frame_rx_if.deframer                rx,
	input  logic                        byte_vld,
	input  uart_frame_pkg::frame_byte_t byte_data
);

	typedef enum logic [1:0] {HUNT, MARK_SEEN, CONTENT, CONTENT_MARK} rx_state_e;

	localparam uart_frame_pkg::frame_len_t FULL = 5'(`LINK_BUF_BYTES);

	rx_state_e                  state;
	uart_frame_pkg::frame_len_t cnt;
	logic                       is_mark;
	logic                       full;
	// set when a frame was dropped, so its closing "&&" is not taken as an opening
	logic                       skip;

	assign is_mark = byte_data == uart_frame_pkg::FRAME_MARK;
	assign full    = cnt == FULL;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= HUNT;
			cnt   <= '0;
			skip  <= 1'b0;
		end else if (byte_vld) begin
			case (state)
				HUNT: if (is_mark)
					state <= MARK_SEEN;
				MARK_SEEN: begin
					state <= HUNT;
					if (is_mark) begin
						if (skip) begin
							skip <= 1'b0;
						end else if (!rx.buf_free) begin
							// previous frame still unread
							skip <= 1'b1;
						end else begin
							state <= CONTENT;
							cnt   <= '0;
						end
					end
				end
				CONTENT: if (is_mark) begin
					state <= CONTENT_MARK;
				end else if (full) begin
					state <= HUNT;
					skip  <= 1'b1;
				end else begin
					cnt <= cnt + 5'd1;
				end
				CONTENT_MARK: state <= HUNT;
				default: state <= HUNT;
			endcase
		end
	end

	assign rx.wr_en    = byte_vld && state == CONTENT && !is_mark && !full;
	assign rx.wr_addr  = cnt[`LINK_BUF_AW-1:0];
	assign rx.wr_data  = byte_data;
	assign rx.len      = cnt;
	assign rx.frame_ok = byte_vld && state == CONTENT_MARK && is_mark;
	assign rx.overflow = byte_vld && state == CONTENT && !is_mark && full;

endmodule

// File: source/axil_link_regs.sv
/*
 * AXI4-Lite slave for the link. Holds the register map and both byte buffers,
 * issues the tx start pulse and keeps the sticky rx flags that drive irq.
 */
`timescale 1ns/10ps
`include "uart_link_settings.svh"

module axil_link_regs (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [7:0]  s_axil_awaddr,
	input  logic        s_axil_awvalid,
	output logic        s_axil_awready,
	input  logic [31:0] s_axil_wdata,
	input  logic [3:0]  s_axil_wstrb,
	input  logic        s_axil_wvalid,
	output logic        s_axil_wready,
	output logic [1:0]  s_axil_bresp,
	output logic        s_axil_bvalid,
	input  logic        s_axil_bready,
	input  logic [7:0]  s_axil_araddr,
	input  logic        s_axil_arvalid,
	output logic        s_axil_arready,
	output logic [31:0] s_axil_rdata,
	output logic [1:0]  s_axil_rresp,
	output logic        s_axil_rvalid,
	input  logic        s_axil_rready,
	output logic        irq,
	frame_tx_if.regs    tx,
	frame_rx_if.regs    rx
);

	logic                       wr_acc;
	logic                       rd_acc;
	logic                       start_q;
	logic                       tx_active;
	logic                       rx_ready;
	logic                       rx_overflow;
	uart_frame_pkg::frame_len_t tx_len;
	uart_frame_pkg::frame_len_t rx_len;
	uart_frame_pkg::frame_byte_t [`LINK_BUF_BYTES-1:0] tx_buf;
	uart_frame_pkg::frame_byte_t [`LINK_BUF_BYTES-1:0] rx_buf;
	axil_regs_pkg::status_t     status;
	logic [31:0]                rd_word;

	assign wr_acc         = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
	assign s_axil_awready = wr_acc;
	assign s_axil_wready  = wr_acc;
	assign s_axil_bresp   = 2'b00;
	assign s_axil_arready = !s_axil_rvalid;
	assign rd_acc         = s_axil_arvalid && !s_axil_rvalid;
	assign s_axil_rresp   = 2'b00;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			s_axil_bvalid <= 1'b0;
			s_axil_rvalid <= 1'b0;
		end else begin
			if (wr_acc)
				s_axil_bvalid <= 1'b1;
			else if (s_axil_bready)
				s_axil_bvalid <= 1'b0;
			if (rd_acc)
				s_axil_rvalid <= 1'b1;
			else if (s_axil_rready)
				s_axil_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rd_acc)
			s_axil_rdata <= rd_word;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			start_q     <= 1'b0;
			tx_active   <= 1'b0;
			rx_ready    <= 1'b0;
			rx_overflow <= 1'b0;
			tx_len      <= '0;
			rx_len      <= '0;
			tx_buf      <= '0;
			rx_buf      <= '0;
		end else begin
			start_q <= 1'b0;
			if (tx.done)
				tx_active <= 1'b0;
			if (wr_acc) begin
				case (s_axil_awaddr)
					axil_regs_pkg::CTRL: if (s_axil_wstrb[0]) begin
						// start is dropped while a frame is in flight
						if (s_axil_wdata[axil_regs_pkg::CTRL_TX_START] &&
						    !tx_active && !tx.busy) begin
							start_q   <= 1'b1;
							tx_active <= 1'b1;
						end
						if (s_axil_wdata[axil_regs_pkg::CTRL_RX_CLEAR]) begin
							rx_ready    <= 1'b0;
							rx_overflow <= 1'b0;
						end
					end
					axil_regs_pkg::TX_LEN: if (s_axil_wstrb[0])
						tx_len <= s_axil_wdata[4:0];
					axil_regs_pkg::TX_BUF0, axil_regs_pkg::TX_BUF1,
					axil_regs_pkg::TX_BUF2, axil_regs_pkg::TX_BUF3: begin
						for (int l = 0; l < 4; l++) begin
							if (s_axil_wstrb[l])
								tx_buf[4 * s_axil_awaddr[3:2] + l] <= s_axil_wdata[8 * l +: 8];
						end
					end
					default: ;
				endcase
			end
			if (rx.wr_en)
				rx_buf[rx.wr_addr] <= rx.wr_data;
			// a new frame wins over a clear in the same cycle
			if (rx.frame_ok) begin
				rx_ready <= 1'b1;
				rx_len   <= rx.len;
			end
			if (rx.overflow)
				rx_overflow <= 1'b1;
		end
	end

	always_comb begin
		status             = '0;
		status.tx_busy     = tx_active;
		status.rx_ready    = rx_ready;
		status.rx_overflow = rx_overflow;
	end

	always_comb begin
		rd_word = '0;
		case (s_axil_araddr)
			axil_regs_pkg::STATUS: rd_word = status;
			axil_regs_pkg::TX_LEN: rd_word = 32'(tx_len);
			axil_regs_pkg::RX_LEN: rd_word = 32'(rx_len);
			axil_regs_pkg::TX_BUF0, axil_regs_pkg::TX_BUF1,
			axil_regs_pkg::TX_BUF2, axil_regs_pkg::TX_BUF3:
				rd_word = tx_buf[4 * s_axil_araddr[3:2] +: 4];
			axil_regs_pkg::RX_BUF0, axil_regs_pkg::RX_BUF1,
			axil_regs_pkg::RX_BUF2, axil_regs_pkg::RX_BUF3:
				rd_word = rx_buf[4 * s_axil_araddr[3:2] +: 4];
			default: rd_word = '0;
		endcase
	end

	assign tx.start    = start_q;
	assign tx.len      = tx_len;
	assign tx.rd_data  = tx_buf[tx.rd_addr];
	assign rx.buf_free = !rx_ready;
	assign irq         = rx_ready;

endmodule

// File: source/uart_link_top.sv
/*
 * Top level of the framed UART link: AXI4-Lite register slave, tx and rx framers
 * and the 8N1 serial blocks, wired together.
 */
`timescale 1ns/10ps

module uart_link_top (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [7:0]  s_axil_awaddr,
	input  logic        s_axil_awvalid,
	output logic        s_axil_awready,
	input  logic [31:0] s_axil_wdata,
	input  logic [3:0]  s_axil_wstrb,
	input  logic        s_axil_wvalid,
	output logic        s_axil_wready,
	output logic [1:0]  s_axil_bresp,
	output logic        s_axil_bvalid,
	input  logic        s_axil_bready,
	input  logic [7:0]  s_axil_araddr,
	input  logic        s_axil_arvalid,
	output logic        s_axil_arready,
	output logic [31:0] s_axil_rdata,
	output logic [1:0]  s_axil_rresp,
	output logic        s_axil_rvalid,
	input  logic        s_axil_rready,
	input  logic        uart_rx_port,
	output logic        uart_tx_port,
	output logic        irq
);

	logic                        byte_req;
	logic                        byte_done;
	uart_frame_pkg::frame_byte_t tx_byte;
	uart_frame_pkg::frame_byte_t rx_byte;
	logic                        rx_vld;

	frame_tx_if u_tx_if ();
	frame_rx_if u_rx_if ();

	axil_link_regs u_regs (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.s_axil_awaddr  (s_axil_awaddr),
		.s_axil_awvalid (s_axil_awvalid),
		.s_axil_awready (s_axil_awready),
		.s_axil_wdata   (s_axil_wdata),
		.s_axil_wstrb   (s_axil_wstrb),
		.s_axil_wvalid  (s_axil_wvalid),
		.s_axil_wready  (s_axil_wready),
		.s_axil_bresp   (s_axil_bresp),
		.s_axil_bvalid  (s_axil_bvalid),
		.s_axil_bready  (s_axil_bready),
		.s_axil_araddr  (s_axil_araddr),
		.s_axil_arvalid (s_axil_arvalid),
		.s_axil_arready (s_axil_arready),
		.s_axil_rdata   (s_axil_rdata),
		.s_axil_rresp   (s_axil_rresp),
		.s_axil_rvalid  (s_axil_rvalid),
		.s_axil_rready  (s_axil_rready),
		.irq            (irq),
		.tx             (u_tx_if.regs),
		.rx             (u_rx_if.regs)
	);

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx        (u_tx_if.framer),
		.byte_req  (byte_req),
		.byte_data (tx_byte),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (byte_req),
		.data      (tx_byte),
		.line      (uart_tx_port),
		.done      (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.line      (uart_rx_port),
		.data      (rx_byte),
		.vld       (rx_vld)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (u_rx_if.deframer),
		.byte_vld  (rx_vld),
		.byte_data (rx_byte)
	);

endmodule

// File: test/uart_link_props.sv
/*
 * Concurrent checks bound into uart_link_top by the testbench.
 * Covers AXI response hold, the idle tx line before the first frame and irq.
 */
`timescale 1ns/10ps

module uart_link_props (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic tx_line,
	input logic tx_start,
	input logic irq,
	input logic frame_ok
);

	// goes high with the first start pulse and stays
	logic started;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			started <= 1'b0;
		else if (tx_start)
			started <= 1'b1;
	end

	bvalid_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// no traffic on the tx line until software starts a frame
	tx_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!started |-> tx_line)
		else $error("uart_tx_port left idle before the first start");

	// irq only comes up the cycle after a complete frame
	irq_after_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(irq) |-> $past(frame_ok))
		else $error("irq rose without a received frame");

endmodule

// File: test/tb_uart_link.sv
/*
 * Testbench for the framed UART link. Drives the AXI4-Lite slave and the rx
 * serial line, decodes the tx line and checks both against a model kept here.
 */
`timescale 1ns/10ps

module tb_uart_link;

	localparam int BIT_CLKS = 16;
	localparam int TIMEOUT  = 5000;

	logic        sys_clk;
	logic        sys_rst_n;
	logic [7:0]  s_axil_awaddr;
	logic        s_axil_awvalid;
	logic        s_axil_awready;
	logic [31:0] s_axil_wdata;
	logic [3:0]  s_axil_wstrb;
	logic        s_axil_wvalid;
	logic        s_axil_wready;
	logic [1:0]  s_axil_bresp;
	logic        s_axil_bvalid;
	logic        s_axil_bready;
	logic [7:0]  s_axil_araddr;
	logic        s_axil_arvalid;
	logic        s_axil_arready;
	logic [31:0] s_axil_rdata;
	logic [1:0]  s_axil_rresp;
	logic        s_axil_rvalid;
	logic        s_axil_rready;
	logic        uart_rx_port;
	logic        uart_tx_port;
	logic        irq;

	// bytes decoded from the tx line, and the bytes the model expects there
	uart_frame_pkg::frame_byte_t line_q[$];
	uart_frame_pkg::frame_byte_t exp_q[$];
	logic [31:0] rng;
	logic        exp_ready;
	logic        exp_ovf;

	uart_link_top u_dut (.*);

	bind uart_link_top uart_link_props u_props (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bvalid    (s_axil_bvalid),
		.bready    (s_axil_bready),
		.rvalid    (s_axil_rvalid),
		.rready    (s_axil_rready),
		.tx_line   (uart_tx_port),
		.tx_start  (u_tx_if.start),
		.irq       (irq),
		.frame_ok  (u_rx_if.frame_ok)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input uart_frame_pkg::frame_byte_t got,
		input uart_frame_pkg::frame_byte_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp));
	endtask

	task automatic check_len(input string name, input uart_frame_pkg::frame_len_t got,
		input uart_frame_pkg::frame_len_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic check_status(input string name, input axil_regs_pkg::status_t got,
		input axil_regs_pkg::status_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR t=%0t %s got %08h expected %08h", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_now($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// payload bytes never carry the mark character
	function automatic uart_frame_pkg::frame_byte_t rand_byte();
		logic [31:0] r;
		uart_frame_pkg::frame_byte_t b;
		r = next_rand();
		b = r[7:0];
		if (b == uart_frame_pkg::FRAME_MARK)
			b = b ^ 8'h01;
		return b;
	endfunction

	function automatic axil_regs_pkg::status_t model_status(input logic busy);
		axil_regs_pkg::status_t s;
		s = '0;
		s.tx_busy     = busy;
		s.rx_ready    = exp_ready;
		s.rx_overflow = exp_ovf;
		return s;
	endfunction

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
		int n;
		int hold;
		@(negedge sys_clk);
		s_axil_awaddr  = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata   = data;
		s_axil_wstrb   = 4'hf;
		s_axil_wvalid  = 1'b1;
		// ready is taken on the edge that accepts the write
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			if (n > 100)
				fail_now("AXI write was never accepted");
		end while (!(s_axil_awready && s_axil_wready));
		@(negedge sys_clk);
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		check_flag("s_axil_bvalid", s_axil_bvalid, 1'b1);
		check_resp("s_axil_bresp", s_axil_bresp, 2'b00);
		// hold the response off for a few cycles
		hold = next_rand() % 4;
		repeat (hold) @(negedge sys_clk);
		check_flag("s_axil_bvalid", s_axil_bvalid, 1'b1);
		s_axil_bready = 1'b1;
		@(negedge sys_clk);
		s_axil_bready = 1'b0;
		check_flag("s_axil_bvalid", s_axil_bvalid, 1'b0);
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		int hold;
		@(negedge sys_clk);
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			if (n > 100)
				fail_now("AXI read address was never accepted");
		end while (!s_axil_arready);
		@(negedge sys_clk);
		s_axil_arvalid = 1'b0;
		check_flag("s_axil_rvalid", s_axil_rvalid, 1'b1);
		check_resp("s_axil_rresp", s_axil_rresp, 2'b00);
		data = s_axil_rdata;
		hold = next_rand() % 4;
		repeat (hold) @(negedge sys_clk);
		check_flag("s_axil_rvalid", s_axil_rvalid, 1'b1);
		s_axil_rready = 1'b1;
		@(negedge sys_clk);
		s_axil_rready = 1'b0;
		check_flag("s_axil_rvalid", s_axil_rvalid, 1'b0);
		check_flag("s_axil_arready", s_axil_arready, 1'b1);
	endtask

	// start bit, eight data bits LSB first, stop bit
	task automatic send_byte(input uart_frame_pkg::frame_byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge sys_clk);
			uart_rx_port = bits[i];
			repeat (BIT_CLKS - 1) @(negedge sys_clk);
		end
	endtask

	task automatic send_frame(input uart_frame_pkg::frame_byte_t pay[$]);
		send_byte(uart_frame_pkg::FRAME_MARK);
		send_byte(uart_frame_pkg::FRAME_MARK);
		foreach (pay[i])
			send_byte(pay[i]);
		send_byte(uart_frame_pkg::FRAME_MARK);
		send_byte(uart_frame_pkg::FRAME_MARK);
	endtask

	task automatic make_payload(input int len, output uart_frame_pkg::frame_byte_t pay[$]);
		pay = {};
		for (int i = 0; i < len; i++)
			pay.push_back(rand_byte());
	endtask

	task automatic expect_status(input logic busy);
		logic [31:0] r;
		axil_read(8'(axil_regs_pkg::STATUS), r);
		check_status("STATUS", axil_regs_pkg::status_t'(r), model_status(busy));
		check_flag("irq", irq, exp_ready);
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (irq !== 1'b1) begin
			@(negedge sys_clk);
			n++;
			if (n > TIMEOUT)
				fail_now("irq did not rise after a complete rx frame");
		end
	endtask

	// RX_LEN and the payload bytes, little-endian in the RX_BUF words
	task automatic check_rx_frame(input uart_frame_pkg::frame_byte_t pay[$]);
		logic [31:0] r;
		axil_read(8'(axil_regs_pkg::RX_LEN), r);
		check_len("RX_LEN", r[4:0], 5'(pay.size()));
		for (int w = 0; w < 4; w++) begin
			axil_read(8'(axil_regs_pkg::RX_BUF0) + 8'(4 * w), r);
			for (int l = 0; l < 4; l++) begin
				if (4 * w + l < pay.size())
					check_byte($sformatf("RX_BUF[%0d]", 4 * w + l), r[8 * l +: 8],
						pay[4 * w + l]);
			end
		end
	endtask

	task automatic rx_clear();
		axil_write(8'(axil_regs_pkg::CTRL), 32'(1) << axil_regs_pkg::CTRL_RX_CLEAR);
		exp_ready = 1'b0;
		exp_ovf   = 1'b0;
		check_flag("irq", irq, 1'b0);
	endtask

	task automatic run_tx(input int len, input bit double_start);
		uart_frame_pkg::frame_byte_t pay[$];
		logic [31:0] w;
		logic [31:0] r;
		int n;
		make_payload(len, pay);
		for (int k = 0; k < 4; k++) begin
			w = '0;
			for (int l = 0; l < 4; l++) begin
				if (4 * k + l < len)
					w[8 * l +: 8] = pay[4 * k + l];
			end
			axil_write(8'(axil_regs_pkg::TX_BUF0) + 8'(4 * k), w);
		end
		exp_q = {uart_frame_pkg::FRAME_MARK, uart_frame_pkg::FRAME_MARK};
		foreach (pay[i])
			exp_q.push_back(pay[i]);
		exp_q.push_back(uart_frame_pkg::FRAME_MARK);
		exp_q.push_back(uart_frame_pkg::FRAME_MARK);
		axil_write(8'(axil_regs_pkg::TX_LEN), 32'(len));
		axil_write(8'(axil_regs_pkg::CTRL), 32'(1) << axil_regs_pkg::CTRL_TX_START);
		// second start lands while busy and must be dropped
		if (double_start)
			axil_write(8'(axil_regs_pkg::CTRL), 32'(1) << axil_regs_pkg::CTRL_TX_START);
		expect_status(1'b1);
		n = 0;
		do begin
			axil_read(8'(axil_regs_pkg::STATUS), r);
			n++;
			if (n > TIMEOUT)
				fail_now("tx_busy never fell after a transmit frame");
		end while (r[0]);
		expect_status(1'b0);
		if (double_start)
			repeat (3 * 10 * BIT_CLKS) @(negedge sys_clk);
		if (line_q.size() != exp_q.size())
			fail_now($sformatf("tx line carried %0d bytes where %0d were expected",
				line_q.size(), exp_q.size()));
		while (exp_q.size() > 0)
			check_byte("uart_tx_port byte", line_q.pop_front(), exp_q.pop_front());
	endtask

	// decodes every byte on the tx line, sampled mid-bit on the falling edge
	initial begin : line_monitor
		uart_frame_pkg::frame_byte_t b;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n === 1'b1 && uart_tx_port === 1'b0) begin
				repeat (BIT_CLKS / 2 - 1) @(negedge sys_clk);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge sys_clk);
					b[i] = uart_tx_port;
				end
				repeat (BIT_CLKS) @(negedge sys_clk);
				if (uart_tx_port !== 1'b1)
					fail_now("no stop bit on uart_tx_port");
				line_q.push_back(b);
			end
		end
	end

	initial begin : main_flow
		uart_frame_pkg::frame_byte_t pay[$];
		uart_frame_pkg::frame_byte_t pay2[$];
		logic [31:0] r;
		int len;
		sys_rst_n      = 1'b0;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wstrb   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		uart_rx_port   = 1'b1;
		rng            = 32'hcbfd_85b9;
		exp_ready      = 1'b0;
		exp_ovf        = 1'b0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;

		expect_status(1'b0);
		axil_write(8'(axil_regs_pkg::TX_LEN), 32'd11);
		axil_read(8'(axil_regs_pkg::TX_LEN), r);
		check_len("TX_LEN", r[4:0], 5'd11);

		run_tx(0, 1'b0);
		run_tx(16, 1'b0);
		for (int t = 0; t < 6; t++) begin
			r = next_rand();
			run_tx(r % 17, 1'b0);
		end

		for (int t = 0; t < 6; t++) begin
			r = next_rand();
			len = (t == 0) ? 16 : r % 17;
			make_payload(len, pay);
			// noise before the opening marks
			for (int i = 0; i < r[9:8]; i++)
				send_byte(rand_byte());
			send_frame(pay);
			wait_irq();
			exp_ready = 1'b1;
			expect_status(1'b0);
			check_rx_frame(pay);
			rx_clear();
		end

		r = next_rand();
		make_payload(17 + r % 4, pay);
		send_frame(pay);
		exp_ovf = 1'b1;
		expect_status(1'b0);
		make_payload(5, pay);
		send_frame(pay);
		wait_irq();
		exp_ready = 1'b1;
		expect_status(1'b0);
		check_rx_frame(pay);
		rx_clear();

		// frame arriving while the previous one is unread
		make_payload(9, pay);
		send_frame(pay);
		wait_irq();
		exp_ready = 1'b1;
		make_payload(4, pay2);
		send_frame(pay2);
		expect_status(1'b0);
		check_rx_frame(pay);
		rx_clear();

		r = next_rand();
		run_tx(1 + r % 16, 1'b1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: tb.f
+incdir+source
source/uart_frame_pkg.sv
source/axil_regs_pkg.sv
source/frame_if.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_tx.sv
source/frame_rx.sv
source/axil_link_regs.sv
source/uart_link_top.sv
test/uart_link_props.sv
test/tb_uart_link.sv

// File: Bender.yml
package:
  name: uart_link

sources:
  - include_dirs:
      - source
    files:
      - source/uart_frame_pkg.sv
      - source/axil_regs_pkg.sv
      - source/frame_if.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/frame_tx.sv
      - source/frame_rx.sv
      - source/axil_link_regs.sv
      - source/uart_link_top.sv
  - target: test
    files:
      - test/uart_link_props.sv
      - test/tb_uart_link.sv
